//--- Bender.yml
package:
  name: pipe_trace

sources:
  - trace_pkg.sv
  - stage_event_if.sv
  - stage_event_capture.sv
  - pipe_trace_tracker.sv
  - trace_record_fifo.sv
  - trace_axil_slave.sv
  - pipe_trace_top.sv
  - target: test
    files:
      - trace_chk.sv
      - tb_pipe_trace.sv

//--- list.f
trace_pkg.sv
stage_event_if.sv
stage_event_capture.sv
pipe_trace_tracker.sv
trace_record_fifo.sv
trace_axil_slave.sv
pipe_trace_top.sv
trace_chk.sv
tb_pipe_trace.sv

//--- pipe_trace_top.sv
`default_nettype none

module pipe_trace_top import trace_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_valid,
    input  logic [31:0]       instr,
    input  logic              pc_stall,
    input  logic              if_id_stall,
    input  logic              if_flush,
    input  logic [addr_w-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [addr_w-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);

    stage_event_if ev ();

    logic               rec_valid;
    trace_rec_t         rec;
    logic               fifo_full;
    logic [drop_w-1:0]  drops;
    logic               drop_clr;
    trace_rec_t         head;
    logic [count_w-1:0] count;
    logic               pop;

    stage_event_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .instr       (instr),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .ev          (ev.src)
    );

    pipe_trace_tracker u_tracker (
        .clk       (clk),
        .rst       (rst),
        .ev        (ev.dst),
        .rec_valid (rec_valid),
        .rec       (rec),
        .fifo_full (fifo_full),
        .drops     (drops),
        .drop_clr  (drop_clr)
    );

    trace_record_fifo u_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rec_valid),
        .din   (rec),
        .full  (fifo_full),
        .pop   (pop),
        .head  (head),
        .count (count)
    );

    trace_axil_slave u_axil (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .head     (head),
        .count    (count),
        .drops    (drops),
        .pop      (pop),
        .drop_clr (drop_clr)
    );

endmodule

`default_nettype wire

//--- pipe_trace_tracker.sv
`default_nettype none

module pipe_trace_tracker import trace_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    stage_event_if.dst        ev,
    output logic              rec_valid,
    output trace_rec_t        rec,
    input  logic              fifo_full,
    output logic [drop_w-1:0] drops,
    input  logic              drop_clr
);

    stage_t     state_q [n_slots];
    stage_t     state_d [n_slots];
    trace_rec_t slot_q  [n_slots];
    trace_rec_t slot_d  [n_slots];

    trace_rec_t fetch_rec;
    trace_rec_t decode_rec;
    logic       fetch_busy;
    logic       decode_busy;
    logic       fetch_adv;
    logic       decode_adv;
    logic       take_new;
    logic       wb_full;

    function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    // ########################################################################
    // Next slot contents for one event
    // ########################################################################

    always_comb begin
        fetch_busy  = (state_q[slot_fetch] == FETCH);
        decode_busy = (state_q[slot_decode] == DECODE);
        decode_adv  = !ev.if_id_stall;
        // Fetch only moves into a decode slot that is free this cycle.
        fetch_adv   = !ev.pc_stall && (!decode_busy || decode_adv);
        take_new    = ev.fetch_valid && (!fetch_busy || fetch_adv);

        // Memory to write-back, which is where the retire stamp is taken.
        state_d[slot_wb] = (state_q[slot_mem] == MEMORY) ? WRITE_BACK : EMPTY;
        slot_d[slot_wb]  = slot_q[slot_mem];
        slot_d[slot_wb].retire_cycle = ev.cycle;

        state_d[slot_mem] = (state_q[slot_exec] == EXECUTE) ? MEMORY : EMPTY;
        slot_d[slot_mem]  = slot_q[slot_exec];

        decode_rec = slot_q[slot_decode];
        if (ev.if_flush) begin
            decode_rec.flushed = 1'b1;
        end
        if (!decode_adv) begin
            decode_rec.decode_stalls = sat_inc(slot_q[slot_decode].decode_stalls);
        end

        state_d[slot_exec] = (decode_busy && decode_adv) ? EXECUTE : EMPTY;
        slot_d[slot_exec]  = decode_rec;

        fetch_rec = slot_q[slot_fetch];
        if (!fetch_adv) begin
            fetch_rec.fetch_stalls = sat_inc(slot_q[slot_fetch].fetch_stalls);
        end

        if (fetch_adv) begin
            state_d[slot_decode] = fetch_busy ? DECODE : EMPTY;
            slot_d[slot_decode]  = slot_q[slot_fetch];
        end else if (decode_adv) begin
            state_d[slot_decode] = EMPTY;
            slot_d[slot_decode]  = decode_rec;
        end else begin
            state_d[slot_decode] = state_q[slot_decode];
            slot_d[slot_decode]  = decode_rec;
        end

        if (take_new) begin
            state_d[slot_fetch] = FETCH;
            slot_d[slot_fetch]  = '{
                instr:         ev.instr,
                fetch_cycle:   ev.cycle,
                fetch_stalls:  '0,
                decode_stalls: '0,
                flushed:       1'b0,
                retire_cycle:  '0
            };
        end else if (fetch_adv) begin
            state_d[slot_fetch] = EMPTY;
            slot_d[slot_fetch]  = fetch_rec;
        end else begin
            state_d[slot_fetch] = state_q[slot_fetch];
            slot_d[slot_fetch]  = fetch_rec;
        end
    end

    // ########################################################################
    // Slot registers and drop counter
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < n_slots; i++) begin
                state_q[i] <= EMPTY;
            end
        end else begin
            for (int i = 0; i < n_slots; i++) begin
                state_q[i] <= state_d[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < n_slots; i++) begin
            slot_q[i] <= slot_d[i];
        end
    end

    assign wb_full   = (state_q[slot_wb] == WRITE_BACK);
    assign rec       = slot_q[slot_wb];
    assign rec_valid = wb_full && !fifo_full;  // A full FIFO turns the retire into a drop.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drops <= '0;
        end else if (drop_clr) begin
            drops <= '0;
        end else if (wb_full && fifo_full && (drops != '1)) begin
            drops <= drops + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- stage_event_capture.sv
`default_nettype none

module stage_event_capture import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  logic [31:0] instr,
    input  logic        pc_stall,
    input  logic        if_id_stall,
    input  logic        if_flush,
    stage_event_if.src  ev
);

    logic [stamp_w-1:0] cycle_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt      <= '0;  // Reads 0 in the first cycle after reset.
            ev.fetch_valid <= 1'b0;
            ev.pc_stall    <= 1'b0;
            ev.if_id_stall <= 1'b0;
            ev.if_flush    <= 1'b0;
            ev.cycle       <= '0;
        end else begin
            cycle_cnt      <= cycle_cnt + 1'b1;
            ev.fetch_valid <= fetch_valid;
            ev.pc_stall    <= pc_stall;
            ev.if_id_stall <= if_id_stall;
            ev.if_flush    <= if_flush;
            ev.cycle       <= cycle_cnt;  // Stamp of the cycle the strobes were sampled.
        end
    end

    always_ff @(posedge clk) begin
        ev.instr <= instr;
    end

endmodule

`default_nettype wire

//--- stage_event_if.sv
`default_nettype none

// One sampled cycle of core strobes plus its cycle stamp.
interface stage_event_if import trace_pkg::*; ();

    logic               fetch_valid;
    logic [31:0]        instr;
    logic               pc_stall;
    logic               if_id_stall;
    logic               if_flush;
    logic [stamp_w-1:0] cycle;

    modport src (
        output fetch_valid, instr, pc_stall, if_id_stall, if_flush, cycle
    );

    modport dst (
        input fetch_valid, instr, pc_stall, if_id_stall, if_flush, cycle
    );

endinterface

`default_nettype wire

//--- tb_pipe_trace.sv
`default_nettype none

module tb_pipe_trace import trace_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        fetch_valid;
        logic [31:0] instr;
        logic        pc_stall;
        logic        if_id_stall;
        logic        if_flush;
    } stim_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              fetch_valid;
    logic [31:0]       instr;
    logic              pc_stall;
    logic              if_id_stall;
    logic              if_flush;
    logic [addr_w-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [addr_w-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;

    stim_t      stim_q [$];
    trace_rec_t exp_q  [$];
    int         exp_drop_cnt = 0;
    int         cycle_cnt    = 0;
    int         cycle_limit  = 0;

    pipe_trace_top uut (.*);

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
            $display("Timeout after %0d cycles, the DUT stopped answering.", cycle_cnt);
            stop_run();
        end
    end

    // The bound checker counts its own assertion failures.
    always @(negedge clk) begin
        if (uut.u_tracker.u_chk.err_cnt != 0) begin
            $display("An assertion in the tracker checker failed at %0t.", $time);
            stop_run();
        end
    end

    // ########################################################################
    // Compare tasks
    // ########################################################################

    task automatic check_rec(input trace_rec_t got, input trace_rec_t want);
        if (got !== want) begin
            $display("FAIL %0t rec got %h expected %h", $time, got, want);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] want);
        if (got !== want) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_status(input logic [count_w-1:0] got_count,
                                input logic [drop_w-1:0]  got_drops,
                                input logic [count_w-1:0] want_count,
                                input logic [drop_w-1:0]  want_drops);
        if (got_count !== want_count) begin
            $display("FAIL %0t count got %0d expected %0d", $time, got_count, want_count);
            stop_run();
        end
        if (got_drops !== want_drops) begin
            $display("FAIL %0t drops got %0d expected %0d", $time, got_drops, want_drops);
            stop_run();
        end
    endtask

    // ########################################################################
    // Vector file and AXI4-Lite master
    // ########################################################################

    task automatic expect_fields(input int got, input int want, input string line);
        if (got != want) begin
            $display("Malformed line in trace_vectors.txt: %s", line);
            stop_run();
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        int          a;
        int          b;
        int          c;
        int          d;
        int          e;
        logic [31:0] word;
        string       line;
        trace_rec_t  r;
        fd = $fopen("trace_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open trace_vectors.txt for reading.");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            case (line[0])
                "S": begin
                    n = $sscanf(line, "S %d %h %d %d %d", a, word, b, c, d);
                    expect_fields(n, 5, line);
                    stim_q.push_back({a[0], word, b[0], c[0], d[0]});
                end
                "E": begin
                    n = $sscanf(line, "E %h %d %d %d %d %d", word, a, b, c, d, e);
                    expect_fields(n, 6, line);
                    r.instr         = word;
                    r.fetch_cycle   = a;
                    r.fetch_stalls  = b[cnt_w-1:0];
                    r.decode_stalls = c[cnt_w-1:0];
                    r.flushed       = d[0];
                    r.retire_cycle  = e;
                    exp_q.push_back(r);
                end
                "D": begin
                    n = $sscanf(line, "D %d", exp_drop_cnt);
                    expect_fields(n, 1, line);
                end
                default: ;  // Comments and blank lines.
            endcase
        end
        $fclose(fd);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [addr_w-1:0] addr, output logic [1:0] resp);
        int delay;
        delay   = $urandom_range(0, 3);
        awaddr  = addr;
        wdata   = 32'h1;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) begin
            step_cycle();
        end
        if (wready !== 1'b1) begin
            $display("FAIL %0t wready got %b expected 1", $time, wready);
            stop_run();
        end
        step_cycle();  // The handshake edge.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (delay) begin
            step_cycle();
        end
        bready = 1'b1;
        while (!bvalid) begin
            step_cycle();
        end
        resp = bresp;
        step_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        delay   = $urandom_range(0, 3);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            step_cycle();
        end
        step_cycle();
        arvalid = 1'b0;
        repeat (delay) begin
            step_cycle();
        end
        rready = 1'b1;
        while (!rvalid) begin
            step_cycle();
        end
        data = rdata;
        resp = rresp;
        step_cycle();
        rready = 1'b0;
    endtask

    task automatic read_status(output logic [count_w-1:0] cnt, output logic [drop_w-1:0] drp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(reg_status, data, resp);
        check_resp("rresp status", resp, resp_okay);
        cnt = data[7:0];
        drp = data[23:8];
    endtask

    task automatic read_head(output trace_rec_t r, input logic [1:0] want);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(reg_instr, data, resp);
        check_resp("rresp instr", resp, want);
        r.instr = data;
        axi_read(reg_fetch_cycle, data, resp);
        check_resp("rresp fetch_cycle", resp, want);
        r.fetch_cycle = data;
        axi_read(reg_stalls, data, resp);
        check_resp("rresp stalls", resp, want);
        r.fetch_stalls  = data[7:0];
        r.decode_stalls = data[15:8];
        r.flushed       = data[16];
        axi_read(reg_retire_cycle, data, resp);
        check_resp("rresp retire_cycle", resp, want);
        r.retire_cycle = data;
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################

    initial begin
        trace_rec_t         got;
        logic [count_w-1:0] cnt;
        logic [drop_w-1:0]  drp;
        logic [31:0]        data;
        logic [1:0]         resp;

        rst         = 1'b1;
        fetch_valid = 1'b0;
        instr       = '0;
        pc_stall    = 1'b0;
        if_id_stall = 1'b0;
        if_flush    = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        void'($urandom(32'h43ea_54b0));
        load_vectors();
        cycle_limit = stim_q.size() + 40 * exp_q.size() + 100;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (stim_q[i]) begin
            {fetch_valid, instr, pc_stall, if_id_stall, if_flush} = stim_q[i];
            step_cycle();
        end

        // Drops are the last thing to change once the pipeline drains.
        do begin
            read_status(cnt, drp);
        end while (drp < exp_drop_cnt);
        check_status(cnt, drp, count_w'(exp_q.size()), drop_w'(exp_drop_cnt));

        foreach (exp_q[i]) begin
            if (i == 0) begin
                axi_read(8'h1C, data, resp);
                check_resp("rresp unknown address", resp, resp_slverr);
                axi_write(8'h20, resp);
                check_resp("bresp unknown address", resp, resp_slverr);
            end
            read_head(got, resp_okay);
            check_rec(got, exp_q[i]);
            axi_write(reg_pop, resp);
            check_resp("bresp pop", resp, resp_okay);
        end

        read_status(cnt, drp);
        check_status(cnt, drp, '0, drop_w'(exp_drop_cnt));
        axi_write(reg_drop_clr, resp);
        check_resp("bresp drop_clr", resp, resp_okay);
        read_status(cnt, drp);
        check_status(cnt, drp, '0, '0);

        // Empty queue, so pops and record reads are refused.
        axi_write(reg_pop, resp);
        check_resp("bresp pop when empty", resp, resp_slverr);
        read_head(got, resp_slverr);
        check_rec(got, '0);

        if (uut.u_tracker.u_chk.err_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("An assertion in the tracker checker failed.");
            stop_run();
        end
    end

endmodule

`default_nettype wire

//--- trace_axil_slave.sv
`default_nettype none

module trace_axil_slave import trace_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [addr_w-1:0]  awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  logic [addr_w-1:0]  araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    input  trace_rec_t         head,
    input  logic [count_w-1:0] count,
    input  logic [drop_w-1:0]  drops,
    output logic               pop,
    output logic               drop_clr
);

    logic        fifo_empty;
    logic        wr_ready_q;
    logic        wr_accept;
    logic        rd_accept;
    logic        wr_cmd;
    logic [1:0]  wr_resp;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    assign fifo_empty = (count == '0);
    assign awready    = wr_ready_q;
    assign wready     = wr_ready_q;
    assign wr_accept  = wr_ready_q && awvalid && wvalid;
    assign rd_accept  = arready && arvalid;
    assign wr_cmd     = wstrb[0] && wdata[0];  // Bit 0 of the written word fires the command.

    // ########################################################################
    // Address decode
    // ########################################################################

    always_comb begin
        case (awaddr)
            reg_pop:      wr_resp = fifo_empty ? resp_slverr : resp_okay;
            reg_drop_clr: wr_resp = resp_okay;
            default:      wr_resp = resp_slverr;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = resp_okay;
        case (araddr)
            reg_status:       rd_data = {{(32 - drop_w - count_w){1'b0}}, drops, count};
            reg_instr:        rd_data = head.instr;
            reg_fetch_cycle:  rd_data = head.fetch_cycle;
            reg_stalls:       rd_data = {{(32 - 2 * cnt_w - 1){1'b0}}, head.flushed,
                                         head.decode_stalls, head.fetch_stalls};
            reg_retire_cycle: rd_data = head.retire_cycle;
            default:          rd_resp = resp_slverr;
        endcase
        // Record registers have nothing to show while the queue is empty.
        if (fifo_empty && (araddr != reg_status)) begin
            rd_data = '0;
            rd_resp = resp_slverr;
        end
    end

    // ########################################################################
    // Channel handshakes
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ready_q <= 1'b0;
            bvalid     <= 1'b0;
            pop        <= 1'b0;
            drop_clr   <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            wr_ready_q <= awvalid && wvalid && !wr_ready_q && !bvalid;  // One-cycle pulse.
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            pop      <= wr_accept && wr_cmd && (awaddr == reg_pop) && !fifo_empty;
            drop_clr <= wr_accept && wr_cmd && (awaddr == reg_drop_clr);
            arready  <= arvalid && !arready && !rvalid;
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
        end
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

//--- trace_chk.sv
`default_nettype none

module trace_chk import trace_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              pc_stall,
    input logic              if_id_stall,
    input logic              rec_valid,
    input logic              fifo_full,
    input stage_t            wb_state,
    input stage_t            mem_state,
    input trace_rec_t        rec,
    input logic [drop_w-1:0] drops,
    input logic              drop_clr
);

    timeunit 1ns;
    timeprecision 100ps;

    int err_cnt = 0;

    // The core never holds decode without also holding fetch.
    stall_order: assert property (@(posedge clk) disable iff (rst) if_id_stall |-> pc_stall)
        else begin
            $error("if_id_stall is high while pc_stall is low");
            err_cnt++;
        end

    // A record reaches write-back only from the memory slot.
    valid_from_wb: assert property (@(posedge clk) disable iff (rst)
        rec_valid |-> (wb_state == WRITE_BACK) && $past(mem_state == MEMORY))
        else begin
            $error("rec_valid without a record moved from memory into write-back");
            err_cnt++;
        end

    // A retire that meets a full FIFO is counted instead of pushed.
    no_push_full: assert property (@(posedge clk) disable iff (rst)
        (wb_state == WRITE_BACK) && fifo_full && !drop_clr
        |=> (drops == $past(drops) + 1'b1) || (drops == '1))
        else begin
            $error("retire into a full FIFO was not counted as a drop");
            err_cnt++;
        end

    retire_stamp: assert property (@(posedge clk) disable iff (rst)
        rec_valid |-> (rec.retire_cycle ==
                       rec.fetch_cycle + rec.fetch_stalls + rec.decode_stalls + 32'd4))
        else begin
            $error("retire_cycle does not match fetch_cycle plus stalls plus 4");
            err_cnt++;
        end

endmodule

bind pipe_trace_tracker trace_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .pc_stall    (ev.pc_stall),
    .if_id_stall (ev.if_id_stall),
    .rec_valid   (rec_valid),
    .fifo_full   (fifo_full),
    .wb_state    (state_q[trace_pkg::slot_wb]),
    .mem_state   (state_q[trace_pkg::slot_mem]),
    .rec         (rec),
    .drops       (drops),
    .drop_clr    (drop_clr)
);

`default_nettype wire

//--- trace_pkg.sv
`default_nettype none

package trace_pkg;

    // ########################################################################
    // Widths and sizes
    // ########################################################################

    localparam int stamp_w    = 32;  // Cycle stamp, one bus word.
    localparam int cnt_w      = 8;   // Saturating stall counter.
    localparam int drop_w     = 16;  // Saturating drop counter.
    localparam int count_w    = 8;   // FIFO occupancy as seen in reg_status.
    localparam int fifo_depth = 8;
    localparam int ptr_w      = $clog2(fifo_depth);
    localparam int addr_w     = 8;   // AXI4-Lite byte address.

    // Slot positions inside the tracker, one per pipeline stage.
    localparam int n_slots     = 5;
    localparam int slot_fetch  = 0;
    localparam int slot_decode = 1;
    localparam int slot_exec   = 2;
    localparam int slot_mem    = 3;
    localparam int slot_wb     = 4;

    typedef enum logic [2:0] {
        EMPTY,
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITE_BACK
    } stage_t;

    typedef struct packed {
        logic [31:0]        instr;
        logic [stamp_w-1:0] fetch_cycle;
        logic [cnt_w-1:0]   fetch_stalls;
        logic [cnt_w-1:0]   decode_stalls;
        logic               flushed;
        logic [stamp_w-1:0] retire_cycle;
    } trace_rec_t;

    // ########################################################################
    // Register map and responses
    // ########################################################################

    localparam logic [addr_w-1:0] reg_status       = 8'h00;
    localparam logic [addr_w-1:0] reg_instr        = 8'h04;
    localparam logic [addr_w-1:0] reg_fetch_cycle  = 8'h08;
    localparam logic [addr_w-1:0] reg_stalls       = 8'h0C;
    localparam logic [addr_w-1:0] reg_retire_cycle = 8'h10;
    localparam logic [addr_w-1:0] reg_pop          = 8'h14;
    localparam logic [addr_w-1:0] reg_drop_clr     = 8'h18;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

//--- trace_record_fifo.sv
`default_nettype none

module trace_record_fifo import trace_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  trace_rec_t         din,
    output logic               full,
    input  logic               pop,
    output trace_rec_t         head,
    output logic [count_w-1:0] count
);

    trace_rec_t       mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == fifo_depth);
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);  // Pops on an empty queue do nothing.
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, so the pointer wraps.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

//--- trace_vectors.txt
# S fetch_valid instr(hex) pc_stall if_id_stall if_flush, one line per cycle from stamp 0
# E instr(hex) fetch_cycle fetch_stalls decode_stalls flushed retire_cycle; D drop count
S 1 00100093 0 0 0
S 1 00200113 0 0 0
S 1 00300193 0 0 0
S 1 00400213 0 0 0
S 0 00000000 1 0 0
S 0 00000000 1 0 0
S 1 00500293 0 0 0
S 0 00000000 1 1 0
S 0 00000000 1 1 0
S 1 00600313 0 0 0
S 1 00700393 0 0 0
S 1 00800413 0 0 1
S 1 00900493 0 0 0
S 1 00a00513 0 0 0
S 0 00000000 0 0 0
E 00100093 0 0 0 0 4
E 00200113 1 0 0 0 5
E 00300193 2 0 0 0 6
E 00400213 3 2 2 0 11
E 00500293 6 2 0 0 12
E 00600313 9 0 0 1 13
E 00700393 10 0 0 0 14
E 00800413 11 0 0 0 15
D 2
